// File: Makefile
SIM = obj_dir/Vtb_mbus
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module tb_mbus

run: compile
	./$(SIM) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+rtl
rtl/mbus_pkg.sv
rtl/shared_ram.sv
rtl/bus_arbiter.sv
rtl/mbus_top.sv
tb/tb_clkgen.sv
tb/mbus_sva.sv
tb/tb_mbus.sv

// File: rtl/bus_arbiter.sv
// time-slices the single memory port between two cores.
// hands the bus over only when the owner sits at an instruction boundary.
`timescale 1ns/1ps
`include "mbus_settings.svh"

module bus_arbiter (
    input  logic                 CLK,
    input  logic                 RST_X,
    input  logic                 init_done,

    input  mbus_pkg::cpu_state_t cpustate_0,
    input  logic [31:0]          paddr_0,
    input  logic                 data_we_0,
    input  logic                 data_le_0,
    input  logic [31:0]          wdata_0,

    input  mbus_pkg::cpu_state_t cpustate_1,
    input  logic [31:0]          paddr_1,
    input  logic                 data_we_1,
    input  logic                 data_le_1,
    input  logic [31:0]          wdata_1,

    input  logic                 mem_busy,
    input  logic [31:0]          mem_rdata,

    output logic                 grant,
    output logic [31:0]          rdata_0,
    output logic                 busy_0,
    output logic [31:0]          rdata_1,
    output logic                 busy_1,

    output mbus_pkg::ram_addr_t  mem_addr,
    output logic                 mem_we,
    output logic                 mem_le,
    output logic [31:0]          mem_wdata
);

    localparam int CNT_W = $clog2(`MBUS_RUN_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MBUS_RUN_CYCLES - 1);

    mbus_pkg::arb_state_t state;
    logic [CNT_W-1:0]     run_cnt;

    mbus_pkg::cpu_state_t sel_cpustate;
    logic [31:0]          sel_paddr;
    logic                 sel_we;
    logic                 sel_le;
    logic [31:0]          sel_wdata;
    logic                 pass_strobe;
    logic                 hold_busy;
    logic                 own_busy;

    // request side follows the current owner.
    assign sel_cpustate = grant ? cpustate_1 : cpustate_0;
    assign sel_paddr    = grant ? paddr_1    : paddr_0;
    assign sel_we       = grant ? data_we_1  : data_we_0;
    assign sel_le       = grant ? data_le_1  : data_le_0;
    assign sel_wdata    = grant ? wdata_1    : wdata_0;

    assign pass_strobe = (state == mbus_pkg::ARB_WAIT) || (state == mbus_pkg::ARB_RUN);
    assign hold_busy   = (state == mbus_pkg::ARB_SWITCH) || (state == mbus_pkg::ARB_SETTLE);

    // byte address to word address.
    assign mem_addr  = sel_paddr[`MBUS_ADDR_W+1:2];
    assign mem_we    = sel_we & pass_strobe;
    assign mem_le    = sel_le & pass_strobe;
    assign mem_wdata = sel_wdata;

    // owner is stalled during the hand-over.
    assign own_busy = hold_busy | mem_busy;

    // the other core is parked with busy high and zero data.
    assign rdata_0 = grant ? 32'd0 : mem_rdata;
    assign busy_0  = grant ? 1'b1  : own_busy;
    assign rdata_1 = grant ? mem_rdata : 32'd0;
    assign busy_1  = grant ? own_busy  : 1'b1;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state   <= mbus_pkg::ARB_WAIT;
            grant   <= 1'b0;
            run_cnt <= '0;
        end else if (init_done) begin
            unique case (state)
                mbus_pkg::ARB_WAIT: begin
                    // idle memory keeps an in-flight response with its core.
                    if (sel_cpustate == mbus_pkg::S_ID && !mem_busy) begin
                        state <= mbus_pkg::ARB_SWITCH;
                    end
                end
                mbus_pkg::ARB_SWITCH: begin
                    grant <= ~grant;
                    state <= mbus_pkg::ARB_SETTLE;
                end
                mbus_pkg::ARB_SETTLE: begin
                    run_cnt <= '0;
                    state   <= mbus_pkg::ARB_RUN;
                end
                mbus_pkg::ARB_RUN: begin
                    if (run_cnt == CNT_LAST) begin
                        state <= mbus_pkg::ARB_WAIT;
                    end else begin
                        run_cnt <= run_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/mbus_pkg.sv
// shared types for the two-core memory bus.
// referenced by scoped names from the arbiter, memory and top level.
`include "mbus_settings.svh"

package mbus_pkg;

    // pipeline state reported by each core.
    // S_ID marks an instruction boundary.
    typedef enum logic [3:0] {
        S_ID = 4'd0,
        S_IF = 4'd1,
        S_EX = 4'd2,
        S_MA = 4'd3
    } cpu_state_t;

    // arbiter phase.
    // wait for a boundary, switch owner, settle, then run a fixed window.
    typedef enum logic [1:0] {
        ARB_WAIT   = 2'd0,
        ARB_SWITCH = 2'd1,
        ARB_SETTLE = 2'd2,
        ARB_RUN    = 2'd3
    } arb_state_t;

    // word address into the shared memory.
    typedef logic [`MBUS_ADDR_W-1:0] ram_addr_t;

endpackage

// File: rtl/mbus_settings.svh
// build-time sizes for the two-core shared memory bus.
// included by the RTL and the testbench.
`ifndef MBUS_SETTINGS_SVH
`define MBUS_SETTINGS_SVH

// word address width into the shared memory (256 words).
`define MBUS_ADDR_W 8

// busy cycles after each accepted load or write strobe.
`define MBUS_RAM_LAT 3

// cycles the new owner keeps the bus after a grant change.
`define MBUS_RUN_CYCLES 4

`endif

// File: rtl/mbus_top.sv
// two-core shared memory bus with the arbiter in front of the shared RAM.
// both core ports and the current grant are brought out.
`timescale 1ns/1ps

module mbus_top (
    input  logic                 CLK,
    input  logic                 RST_X,
    input  logic                 init_done,
    output logic                 grant,

    input  mbus_pkg::cpu_state_t cpustate_0,
    input  logic [31:0]          paddr_0,
    input  logic                 data_we_0,
    input  logic                 data_le_0,
    input  logic [31:0]          wdata_0,
    output logic [31:0]          rdata_0,
    output logic                 busy_0,

    input  mbus_pkg::cpu_state_t cpustate_1,
    input  logic [31:0]          paddr_1,
    input  logic                 data_we_1,
    input  logic                 data_le_1,
    input  logic [31:0]          wdata_1,
    output logic [31:0]          rdata_1,
    output logic                 busy_1
);

    mbus_pkg::ram_addr_t mem_addr;
    logic                mem_we;
    logic                mem_le;
    logic [31:0]         mem_wdata;
    logic                mem_busy;
    logic [31:0]         mem_rdata;

    bus_arbiter u_arb (
        .CLK        (CLK),
        .RST_X      (RST_X),
        .init_done  (init_done),
        .cpustate_0 (cpustate_0),
        .paddr_0    (paddr_0),
        .data_we_0  (data_we_0),
        .data_le_0  (data_le_0),
        .wdata_0    (wdata_0),
        .cpustate_1 (cpustate_1),
        .paddr_1    (paddr_1),
        .data_we_1  (data_we_1),
        .data_le_1  (data_le_1),
        .wdata_1    (wdata_1),
        .mem_busy   (mem_busy),
        .mem_rdata  (mem_rdata),
        .grant      (grant),
        .rdata_0    (rdata_0),
        .busy_0     (busy_0),
        .rdata_1    (rdata_1),
        .busy_1     (busy_1),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_le     (mem_le),
        .mem_wdata  (mem_wdata)
    );

    shared_ram u_ram (
        .CLK       (CLK),
        .RST_X     (RST_X),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_le    (mem_le),
        .mem_wdata (mem_wdata),
        .mem_busy  (mem_busy),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: rtl/shared_ram.sv
// word-addressed shared memory with a fixed busy interval per access.
// read data is published when busy falls and held until the next load.
`timescale 1ns/1ps
`include "mbus_settings.svh"

module shared_ram (
    input  logic                CLK,
    input  logic                RST_X,
    input  mbus_pkg::ram_addr_t mem_addr,
    input  logic                mem_we,
    input  logic                mem_le,
    input  logic [31:0]         mem_wdata,
    output logic                mem_busy,
    output logic [31:0]         mem_rdata
);

    localparam int DEPTH = 1 << `MBUS_ADDR_W;
    localparam int LAT_W = $clog2(`MBUS_RAM_LAT + 1);
    localparam logic [LAT_W-1:0] LAT_LOAD = LAT_W'(`MBUS_RAM_LAT);
    localparam logic [LAT_W-1:0] LAT_ONE  = LAT_W'(1);

    logic [31:0]      mem [0:DEPTH-1];
    logic [LAT_W-1:0] lat_cnt;
    logic             load_pend;
    logic [31:0]      rd_word;
    logic             accept;

    assign mem_busy = (lat_cnt != '0);

    // strobes during busy are dropped.
    assign accept = !mem_busy && (mem_we || mem_le);

    // storage and captured read word.
    always_ff @(posedge CLK) begin
        if (!mem_busy && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        if (!mem_busy && mem_le) begin
            rd_word <= mem[mem_addr];
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            lat_cnt   <= '0;
            load_pend <= 1'b0;
            mem_rdata <= 32'd0;
        end else if (accept) begin
            lat_cnt   <= LAT_LOAD;
            load_pend <= mem_le;
        end else if (mem_busy) begin
            lat_cnt <= lat_cnt - 1'b1;
            // last busy cycle of a load.
            if (lat_cnt == LAT_ONE && load_pend) begin
                mem_rdata <= rd_word;
                load_pend <= 1'b0;
            end
        end
    end

endmodule

// File: tb/mbus_sva.sv
// grant and busy rules of the bus arbiter.
// bound to every bus_arbiter instance from the testbench top.
`timescale 1ns/1ps

module mbus_sva (
    input logic                 CLK,
    input logic                 RST_X,
    input mbus_pkg::arb_state_t state,
    input logic                 grant,
    input logic                 busy_0,
    input logic                 busy_1,
    input logic                 mem_we,
    input logic                 mem_le
);

    logic hand_over;

    assign hand_over = (state == mbus_pkg::ARB_SWITCH) || (state == mbus_pkg::ARB_SETTLE);

    // owner changes only at the end of the switch phase.
    a_grant_stable: assert property (@(posedge CLK) disable iff (!RST_X)
        (state != mbus_pkg::ARB_SWITCH) |=> $stable(grant))
        else $error("grant changed outside ARB_SWITCH");

    a_park_0: assert property (@(posedge CLK) disable iff (!RST_X) grant |-> busy_0)
        else $error("busy_0 low while core 1 owns the bus");

    a_park_1: assert property (@(posedge CLK) disable iff (!RST_X) !grant |-> busy_1)
        else $error("busy_1 low while core 0 owns the bus");

    a_no_strobe: assert property (@(posedge CLK) disable iff (!RST_X)
        hand_over |-> !(mem_we || mem_le))
        else $error("memory strobe during the hand-over");

endmodule

// File: tb/tb_clkgen.sv
// clock and reset source for the bus testbench.
// 40 ns clock, reset held low for the first 4 rising edges.
`timescale 1ns/1ps

module tb_clkgen (
    output logic CLK,
    output logic RST_X
);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // release a little after the edge like the other inputs.
    initial begin
        RST_X = 1'b0;
        repeat (4) @(posedge CLK);
        #2;
        RST_X = 1'b1;
    end

endmodule

// File: tb/tb_mbus.sv
// testbench for the two-core shared memory bus.
// seeded random traffic from two cores, checked against a cycle model of grant and memory.
`timescale 1ns/1ps
`include "mbus_settings.svh"

module tb_mbus;

    localparam int N_OPS   = 400;
    localparam int MAX_CYC = 20000;
    localparam int RUN     = `MBUS_RUN_CYCLES;
    localparam int DEPTH   = 1 << `MBUS_ADDR_W;
    localparam int PH_IF   = 0;
    localparam int PH_EX   = 1;
    localparam int PH_MA   = 2;
    localparam int PH_BUSY = 3;
    localparam int PH_ID   = 4;

    logic                 CLK;
    logic                 RST_X;
    logic                 init_done;
    logic                 grant;
    mbus_pkg::cpu_state_t cpustate [2];
    logic [31:0]          paddr [2];
    logic                 data_we [2];
    logic                 data_le [2];
    logic [31:0]          wdata [2];
    logic [31:0]          rdata [2];
    logic                 busy [2];

    // reference memory and model state after the last edge.
    logic [31:0] ref_mem [DEPTH];
    logic        written [DEPTH];
    logic        m_grant = 1'b0;
    int          m_left = 0;
    int          m_busy = 0;
    logic        m_pend = 1'b0;
    logic [31:0] m_rd = 32'd0;
    logic [31:0] m_rdata = 32'd0;

    int ph [2];
    int idle [2];
    int seed;
    int ops_done;
    int wait_init;
    int cycles = 0;

    tb_clkgen u_clk (.CLK(CLK), .RST_X(RST_X));

    mbus_top u_dut (
        .CLK(CLK), .RST_X(RST_X), .init_done(init_done), .grant(grant),
        .cpustate_0(cpustate[0]), .paddr_0(paddr[0]), .data_we_0(data_we[0]),
        .data_le_0(data_le[0]), .wdata_0(wdata[0]), .rdata_0(rdata[0]), .busy_0(busy[0]),
        .cpustate_1(cpustate[1]), .paddr_1(paddr[1]), .data_we_1(data_we[1]),
        .data_le_1(data_le[1]), .wdata_1(wdata[1]), .rdata_1(rdata[1]), .busy_1(busy[1])
    );

    bind bus_arbiter mbus_sva u_sva (
        .CLK(CLK), .RST_X(RST_X), .state(state), .grant(grant),
        .busy_0(busy_0), .busy_1(busy_1), .mem_we(mem_we), .mem_le(mem_le)
    );

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
        abort_run();
    endtask

    // advance the model by one edge with the inputs the DUT just sampled.
    task automatic model_step();
        int                  g;
        logic                pass_ok;
        logic                mem_idle;
        mbus_pkg::ram_addr_t a;
        g        = int'(m_grant);
        pass_ok  = (m_left <= RUN);
        mem_idle = (m_busy == 0);
        a        = paddr[g][`MBUS_ADDR_W+1:2];
        if (mem_idle && pass_ok && (data_we[g] || data_le[g])) begin
            m_busy = `MBUS_RAM_LAT;
            m_pend = data_le[g];
            m_rd   = ref_mem[a];
            if (data_we[g]) begin
                ref_mem[a] = wdata[g];
                written[a] = 1'b1;
            end
        end else if (!mem_idle) begin
            m_busy = m_busy - 1;
            if (m_busy == 0 && m_pend) begin
                m_rdata = m_rd;
            end
        end
        // switch, settle, then the run window.
        if (init_done && m_left == 0 && cpustate[g] == mbus_pkg::S_ID && mem_idle) begin
            m_left = RUN + 2;
        end else if (init_done && m_left > 0) begin
            m_grant = (m_left == RUN + 2) ? ~m_grant : m_grant;
            m_left  = m_left - 1;
        end
    endtask

    task automatic check_outputs();
        int          c;
        logic        exp_busy;
        logic [31:0] exp_rdata;
        assert (grant === m_grant)
            else report_mismatch("grant", 32'(grant), 32'(m_grant));
        for (c = 0; c < 2; c++) begin
            // parked core sees busy high and zero data.
            exp_busy  = (c != int'(m_grant)) || (m_left > RUN) || (m_busy != 0);
            exp_rdata = (c == int'(m_grant)) ? m_rdata : 32'd0;
            assert (busy[c] === exp_busy)
                else report_mismatch($sformatf("busy_%0d", c), 32'(busy[c]), 32'(exp_busy));
            assert (rdata[c] === exp_rdata)
                else report_mismatch($sformatf("rdata_%0d", c), rdata[c], exp_rdata);
        end
    endtask

    // one cycle of a modelled core.
    task automatic drive_core(input int c);
        logic [31:0]         r;
        mbus_pkg::ram_addr_t a;
        r          = $random(seed);
        a          = mbus_pkg::ram_addr_t'(r[3:0]);
        data_we[c] = 1'b0;
        data_le[c] = 1'b0;
        case (ph[c])
            PH_IF, PH_EX: begin
                cpustate[c] = (ph[c] == PH_IF) ? mbus_pkg::S_IF : mbus_pkg::S_EX;
                ph[c]       = ph[c] + 1;
            end
            PH_MA: begin
                cpustate[c] = mbus_pkg::S_MA;
                paddr[c]    = 32'(a) << 2;
                wdata[c]    = $random(seed);
                if (!busy[c]) begin
                    // some instructions skip memory. loads only hit written words.
                    data_le[c] = (r[5:4] != 2'd0) && r[6] && written[a];
                    data_we[c] = (r[5:4] != 2'd0) && !data_le[c];
                    ph[c]      = PH_BUSY;
                end else if (r[9:7] == 3'd0) begin
                    // the bus must drop this stray write while busy is high.
                    data_we[c] = 1'b1;
                end
            end
            PH_BUSY: begin
                if (!busy[c]) begin
                    cpustate[c] = mbus_pkg::S_ID;
                    idle[c]     = int'(r[1:0]);
                    ph[c]       = PH_ID;
                    ops_done    = ops_done + 1;
                end
            end
            default: begin
                if (idle[c] == 0) begin
                    ph[c] = PH_IF;
                end else begin
                    idle[c] = idle[c] - 1;
                end
            end
        endcase
    endtask

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYC) begin
            $display("timeout: traffic did not finish within %0d cycles", MAX_CYC);
            abort_run();
        end
    end

    initial begin
        seed      = 33891;
        ops_done  = 0;
        init_done = 1'b0;
        cpustate  = '{default: mbus_pkg::S_ID};
        paddr     = '{default: 32'd0};
        data_we   = '{default: 1'b0};
        data_le   = '{default: 1'b0};
        wdata     = '{default: 32'd0};
        ph        = '{default: PH_ID};
        idle      = '{default: 0};
        written   = '{default: 1'b0};
        wait_init = 2 + ($random(seed) & 7);
        @(posedge RST_X);
        while (ops_done < N_OPS) begin
            @(posedge CLK);
            model_step();
            #1;
            check_outputs();
            #1;
            if (!init_done) begin
                // cores sit at S_ID until the system is up.
                init_done = (wait_init == 0);
                wait_init = wait_init - 1;
            end else begin
                drive_core(0);
                drive_core(1);
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
